// ==== mips_core.f ====
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_regbank.sv
hw/mips_execute.sv
hw/mips_core.sv
tests/tb_clock.sv
tests/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the MIPS core testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module mips_core_tb -f mips_core.f -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -q -F "** PASS **" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tests/mips_core_tb.sv ====
// Testbench of the MIPS core, running a random program and checking the data bus against a model.
`timescale 1ns/1ns

module mips_core_tb import mips_pkg::*; ();

    localparam word_t RESET_ADDR = 32'hbfc00000;
    localparam int    PROG_LEN   = 2000;        // Program words.
    localparam int    SEED       = 81;

    // Kept R-type functions, constant shifts first.
    localparam logic [5:0] R_FN [16] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [5:0] I_OP [8] = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
        OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI};

    logic     CLK;
    logic     RESET_I;
    word_t    caddr;
    word_t    crdata;
    word_t    daddr;
    word_t    dwdata;
    logic     dwrite;

    word_t    prog [$];                         // Code memory from RESET_ADDR.
    word_t    regs [32];                        // Model register file.
    word_t    st_addr_q [$];                    // Expected stores in order.
    word_t    st_data_q [$];
    reg_idx_t last1;                            // Recent destinations for forwarding.
    reg_idx_t last2;
    reg_idx_t last3;
    word_t    fetch_addr;                       // caddr of the previous cycle.
    word_t    exp_pc;
    logic     pc_started;
    logic     data_due;                         // Store data expected this cycle.
    word_t    due_data;

    tb_clock clock_gen (.CLK(CLK), .RESET_I(RESET_I));

    mips_core #(.RESET_ADDR(RESET_ADDR)) uut (
        .CLK(CLK), .RESET_I(RESET_I), .caddr(caddr), .crdata(crdata),
        .daddr(daddr), .dwrite(dwrite), .dwdata(dwdata)
    );

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic show_mismatch(string sig, word_t exp, word_t act);
        $display("Fail at %0t ns: %s expected %08h, got %08h", $time, sig, exp, act);
        stop_run();
    endtask

    task automatic describe_error(string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    // One instruction in program order.
    task automatic model_exec(word_t insn);
        reg_idx_t rs;
        reg_idx_t dst;
        word_t    a;
        word_t    b;
        word_t    sx;
        word_t    zx;
        word_t    res;
        logic     wr;
        rs  = insn[25:21];
        a   = regs[rs];
        b   = regs[insn[20:16]];
        sx  = {{16{insn[15]}}, insn[15:0]};     // Sign-extended immediate.
        zx  = {16'h0, insn[15:0]};
        dst = (insn[31:26] == OPC_SPECIAL) ? insn[15:11] : insn[20:16];
        res = '0;
        wr  = 1'b1;
        if (insn[31:26] == OPC_SPECIAL) begin
            case (insn[5:0])
            FN_SLL:          res = b << insn[10:6];
            FN_SRL:          res = b >> insn[10:6];
            FN_SRA:          res = word_t'($signed(b) >>> insn[10:6]);
            FN_SLLV:         res = b << a[4:0];
            FN_SRLV:         res = b >> a[4:0];
            FN_SRAV:         res = word_t'($signed(b) >>> a[4:0]);
            FN_ADD, FN_ADDU: res = a + b;           // No overflow trap.
            FN_SUB, FN_SUBU: res = a - b;
            FN_AND:          res = a & b;
            FN_OR:           res = a | b;
            FN_XOR:          res = a ^ b;
            FN_NOR:          res = ~(a | b);
            FN_SLT:          res = {31'h0, $signed(a) < $signed(b)};
            FN_SLTU:         res = {31'h0, a < b};
            default:         wr = 1'b0;             // Unknown function.
            endcase
            if (insn[5:2] == 4'b0000 && rs != REG_ZERO) begin
                wr = 1'b0;                      // Constant shifts need rs zero.
            end
        end else begin
            case (insn[31:26])
            OPC_ADDI, OPC_ADDIU: res = a + sx;
            OPC_SLTI:            res = {31'h0, $signed(a) < $signed(sx)};
            OPC_SLTIU:           res = {31'h0, a < sx};
            OPC_ANDI:            res = a & zx;
            OPC_ORI:             res = a | zx;
            OPC_XORI:            res = a ^ zx;
            OPC_LUI:             res = {insn[15:0], 16'h0};
            OPC_SW: begin
                wr = 1'b0;
                st_addr_q.push_back(a + sx);
                st_data_q.push_back(b);
            end
            default:             wr = 1'b0;     // Retires as a bubble.
            endcase
        end
        if (wr && dst != REG_ZERO) begin
            regs[dst] = res;
        end
    endtask

    task automatic emit(word_t insn);
        prog.push_back(insn);
        model_exec(insn);
    endtask

    // Mostly a recent destination, so distances one to three get hit.
    function automatic reg_idx_t pick_source();
        case ($urandom_range(0, 5))
        0:       return last1;
        1:       return last2;
        2:       return last3;
        default: return reg_idx_t'($urandom_range(0, 31));
        endcase
    endfunction

    task automatic init_registers();
        word_t v;
        for (int r = 1; r < 32; r++) begin
            v = $urandom();
            if ($urandom_range(0, 1) == 0) begin
                emit({OPC_ADDIU, REG_ZERO, reg_idx_t'(r), v[15:0]});
            end else begin
                emit({OPC_LUI, REG_ZERO, reg_idx_t'(r), v[31:16]});
                emit({OPC_ORI, reg_idx_t'(r), reg_idx_t'(r), v[15:0]});
            end
        end
    endtask

    task automatic add_random_insn();
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [3:0]  k;
        int unsigned mix;
        rs  = pick_source();
        rt  = pick_source();
        rd  = reg_idx_t'($urandom_range(0, 31));  // r0 now and then.
        k   = 4'($urandom_range(0, 15));
        mix = $urandom_range(0, 99);
        if (mix < 20) begin
            emit({OPC_SW, rs, rt, 16'($urandom())});
        end else if (mix < 23) begin
            case (k[1:0])                       // Loads, branches, JR.
            2'd0:    emit({3'b100, 3'($urandom()), 26'($urandom())});
            2'd1:    emit({3'b000, 3'($urandom_range(1, 7)), 26'($urandom())});
            default: emit({OPC_SPECIAL, 20'($urandom()), 6'b001000});
            endcase
        end else if (mix < 60) begin
            if (k < 4'd3) begin
                emit({OPC_SPECIAL, REG_ZERO, rt, rd, 5'($urandom()), R_FN[k]});
            end else begin
                emit({OPC_SPECIAL, rs, rt, rd, 5'd0, R_FN[k]});
            end
        end else begin
            emit({I_OP[k[2:0]], rs, rd, 16'($urandom())});  // rd sits in the rt field.
        end
        if (mix >= 23) begin
            last3 = last2;
            last2 = last1;
            last1 = rd;
        end
    endtask

    function automatic word_t code_word(word_t addr);
        int idx;
        idx = int'((addr - RESET_ADDR) >> 2);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return {OPC_ORI, REG_ZERO, REG_ZERO, addr[31:16] ^ addr[15:0]};  // Harmless r0 writes.
    endfunction

    // Data phase answers the previous address phase.
    initial begin : code_bus
        crdata     = '0;
        fetch_addr = RESET_ADDR;
        forever begin
            @(posedge CLK);
            #1;
            crdata     = code_word(fetch_addr);
            fetch_addr = caddr;
        end
    end

    initial begin : bus_monitor
        pc_started   = 1'b0;
        data_due     = 1'b0;
        forever begin
            @(negedge CLK);
            if (data_due) begin
                assert (dwdata == due_data) else show_mismatch("dwdata", due_data, dwdata);
                data_due = 1'b0;
            end
            if (RESET_I) begin
                assert (!dwrite) else describe_error("dwrite pulsed while reset was high");
                assert (caddr == RESET_ADDR) else show_mismatch("caddr", RESET_ADDR, caddr);
            end else begin
                if (!pc_started) begin
                    exp_pc     = RESET_ADDR;    // First cycle after reset.
                    pc_started = 1'b1;
                end
                assert (caddr == exp_pc) else show_mismatch("caddr", exp_pc, caddr);
                exp_pc = exp_pc + 32'd4;
                if (dwrite) begin
                    assert (st_addr_q.size() > 0)
                        else describe_error("store strobe with no store left in the model");
                    assert (daddr == st_addr_q[0]) else show_mismatch("daddr", st_addr_q[0], daddr);
                    void'(st_addr_q.pop_front());
                    due_data = st_data_q.pop_front();
                    data_due = 1'b1;            // Data follows one cycle later.
                end
            end
        end
    end

    initial begin : watchdog
        #((PROG_LEN + 20) * 4);
        describe_error("timeout, the program did not run to its end");
    end

    initial begin : main
        word_t end_addr;
        void'($urandom(SEED));
        regs         = '{default: '0};
        last1        = 5'd1;
        last2        = 5'd2;
        last3        = 5'd3;
        init_registers();
        while (prog.size() < PROG_LEN) begin
            add_random_insn();
        end
        // Last store data is out four cycles after its fetch.
        end_addr = RESET_ADDR + word_t'(4 * (prog.size() + 6));
        @(negedge CLK);
        while (RESET_I || caddr != end_addr) begin
            @(negedge CLK);
        end
        assert (st_addr_q.size() == 0)
            else describe_error("some stores of the program never reached the data bus");
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
// Clock and reset generator of the core testbench, instantiated once by the testbench top.
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD  = 2,             // 4 ns clock.
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic RESET_I
);

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // Released just after a rising edge, like every other input.
    initial begin
        RESET_I = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET_I = 1'b0;
    end

endmodule

// ==== hw/mips_core.sv ====
// Top level of the five-stage MIPS integer core, instantiated by the testbench as the DUT.
`timescale 1ns/1ns

module mips_core import mips_pkg::*; #(
    parameter word_t RESET_ADDR = 32'hbfc00000     // First fetch address.
) (
    input  logic  CLK,
    input  logic  RESET_I,
    output word_t caddr,                        // Code bus address phase.
    input  word_t crdata,                       // Code bus data phase.
    output word_t daddr,                        // Store address.
    output logic  dwrite,                       // Store strobe.
    output word_t dwdata                        // Store data, one cycle after strobe.
);

    word_t     ir;                              // Instruction register.
    logic      ir_valid;
    alu_op_t   alu_op;
    arg0_sel_t arg0_sel;
    arg1_sel_t arg1_sel;
    word_t     imm;
    reg_idx_t  rd_index;
    logic      dec_wb_en;                       // Decoded writeback enable.
    logic      store_en;
    word_t     rs_value;                        // Forwarded rs.
    word_t     rt_value;                        // Forwarded rt.
    logic      ex_wb_en;                        // Execute stage forward pair.
    reg_idx_t  ex_rd_index;
    word_t     ex_result;
    logic      wb_en;                           // Writeback stage write port.
    reg_idx_t  wb_rd_index;
    word_t     wb_data;

    mips_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .CLK(CLK), .RESET_I(RESET_I), .crdata(crdata), .caddr(caddr),
        .ir(ir), .ir_valid(ir_valid)
    );

    mips_decode u_decode (
        .ir(ir), .ir_valid(ir_valid), .alu_op(alu_op), .arg0_sel(arg0_sel),
        .arg1_sel(arg1_sel), .imm(imm), .rd_index(rd_index), .wb_en(dec_wb_en),
        .store_en(store_en)
    );

    mips_regbank u_regbank (
        .CLK(CLK), .ir(ir), .ex_wb_en(ex_wb_en), .wb_en(wb_en),
        .ex_rd_index(ex_rd_index), .wb_rd_index(wb_rd_index), .ex_result(ex_result),
        .wb_data(wb_data), .rs_value(rs_value), .rt_value(rt_value)
    );

    mips_execute u_execute (
        .CLK(CLK), .RESET_I(RESET_I), .alu_op(alu_op), .arg0_sel(arg0_sel),
        .arg1_sel(arg1_sel), .imm(imm), .rd_index(rd_index), .dec_wb_en(dec_wb_en),
        .store_en(store_en), .rs_value(rs_value), .rt_value(rt_value),
        .ex_wb_en(ex_wb_en), .ex_rd_index(ex_rd_index), .ex_result(ex_result),
        .wb_en(wb_en), .wb_rd_index(wb_rd_index), .wb_data(wb_data),
        .daddr(daddr), .dwdata(dwdata), .dwrite(dwrite)
    );

endmodule

// ==== hw/mips_execute.sv ====
// Execute and writeback stages of the core, also driving the data bus for word stores.
`timescale 1ns/1ns

module mips_execute import mips_pkg::*; (
    input  logic      CLK,
    input  logic      RESET_I,
    input  alu_op_t   alu_op,                   // Decode controls.
    input  arg0_sel_t arg0_sel,
    input  arg1_sel_t arg1_sel,
    input  word_t     imm,
    input  reg_idx_t  rd_index,
    input  logic      dec_wb_en,
    input  logic      store_en,
    input  word_t     rs_value,                 // Forwarded operands.
    input  word_t     rt_value,
    output logic      ex_wb_en,                 // Forward pair of execute stage.
    output reg_idx_t  ex_rd_index,
    output word_t     ex_result,
    output logic      wb_en,                    // Bank write port.
    output reg_idx_t  wb_rd_index,
    output word_t     wb_data,
    output word_t     daddr,
    output word_t     dwdata,
    output logic      dwrite
);

    word_t   arg0;                              // Selected in decode cycle.
    word_t   arg1;
    word_t   st_addr;                           // rs plus offset.
    alu_op_t ex_op;                             // Decode to execute registers.
    word_t   ex_arg0;
    word_t   ex_arg1;
    word_t   ex_addr;
    word_t   ex_sdata;
    logic    ex_store;

    // Operand muxes.
    always_comb begin
        case (arg0_sel)
        A0_RS:    arg0 = rs_value;
        A0_SHAMT: arg0 = imm;
        default:  arg0 = '0;
        endcase
        case (arg1_sel)
        A1_RT:    arg1 = rt_value;
        A1_IMM:   arg1 = imm;
        default:  arg1 = '0;
        endcase
    end

    assign st_addr = rs_value + imm;

    // Enables double as the stage valid bits.
    always_ff @(posedge CLK) begin
        if (RESET_I) begin
            ex_wb_en <= 1'b0;
            ex_store <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            ex_wb_en <= dec_wb_en;
            ex_store <= store_en;
            wb_en    <= ex_wb_en;
        end
    end

    // Payload registers.
    always_ff @(posedge CLK) begin
        ex_op       <= alu_op;
        ex_arg0     <= arg0;
        ex_arg1     <= arg1;
        ex_rd_index <= rd_index;
        ex_addr     <= st_addr;
        ex_sdata    <= rt_value;
        wb_rd_index <= ex_rd_index;
        wb_data     <= ex_result;
        dwdata      <= ex_sdata;                // Data phase of the store.
    end

    mips_alu u_alu (
        .alu_op(ex_op),
        .arg0(ex_arg0),
        .arg1(ex_arg1),
        .result(ex_result)
    );

    // Address phase of the store.
    assign dwrite = ex_store;
    assign daddr  = ex_addr;

endmodule

// ==== hw/mips_regbank.sv ====
// Register bank of the core, with two forwarded read ports for decode and one write port.
`timescale 1ns/1ns

module mips_regbank import mips_pkg::*; (
    input  logic     CLK,
    input  word_t    ir,                        // Instruction in decode.
    input  logic     ex_wb_en,                  // Execute stage will write.
    input  logic     wb_en,                     // Writeback stage writes now.
    input  reg_idx_t ex_rd_index,
    input  reg_idx_t wb_rd_index,
    input  word_t    ex_result,                 // Combinational ALU result.
    input  word_t    wb_data,
    output word_t    rs_value,
    output word_t    rt_value
);

    word_t    bank [32];                        // r0 slot is never read.
    reg_idx_t rs_index;
    reg_idx_t rt_index;

    // Newest producer wins.
    function automatic word_t read_fwd(reg_idx_t idx);
        word_t val;
        if (ex_wb_en && (ex_rd_index == idx)) begin
            val = ex_result;
        end else if (wb_en && (wb_rd_index == idx)) begin
            val = wb_data;
        end else if (idx == REG_ZERO) begin
            val = '0;
        end else begin
            val = bank[idx];
        end
        return val;
    endfunction

    assign rs_index = ir[25:21];
    assign rt_index = ir[20:16];

    // Forwarded read ports.
    always_comb begin
        rs_value = read_fwd(rs_index);
        rt_value = read_fwd(rt_index);
    end

    // Write port.
    always_ff @(posedge CLK) begin
        if (wb_en) begin
            bank[wb_rd_index] <= wb_data;
        end
    end

endmodule

// ==== hw/mips_decode.sv ====
// Decode stage of the core, turning the IR into ALU, operand, immediate and writeback controls.
`timescale 1ns/1ns

module mips_decode import mips_pkg::*; (
    input  word_t     ir,                       // Instruction register.
    input  logic      ir_valid,
    output alu_op_t   alu_op,
    output arg0_sel_t arg0_sel,
    output arg1_sel_t arg1_sel,
    output word_t     imm,                      // Immediate in final form.
    output reg_idx_t  rd_index,                 // Destination register.
    output logic      wb_en,                    // Register write, valid gated.
    output logic      store_en                  // Word store, valid gated.
);

    localparam int CTL_W = 13;                  // Width of packed table entry.

    logic [CTL_W-1:0] ctl;                      // Table output.
    imm_kind_t        imm_kind;
    logic             tbl_wb;                   // Writes a register.
    logic             tbl_st;                   // Stores a word.
    logic [5:0]       opcode;

    // One table entry, packed as {wb, store, kind, arg0, arg1, op}.
    function automatic logic [CTL_W-1:0] entry(alu_op_t op, arg0_sel_t a0, arg1_sel_t a1,
                                               imm_kind_t kind, logic wb, logic st);
        return {wb, st, kind, a0, a1, op};
    endfunction

    assign opcode = ir[31:26];

    // Decoding table.
    always_comb begin
        casez (ir)
        {OPC_SPECIAL, 5'd0, 15'b?, FN_SLL}:  ctl = entry(ALU_SLL, A0_SHAMT, A1_RT, IMM_SHAMT, 1'b1, 1'b0);
        {OPC_SPECIAL, 5'd0, 15'b?, FN_SRL}:  ctl = entry(ALU_SRL, A0_SHAMT, A1_RT, IMM_SHAMT, 1'b1, 1'b0);
        {OPC_SPECIAL, 5'd0, 15'b?, FN_SRA}:  ctl = entry(ALU_SRA, A0_SHAMT, A1_RT, IMM_SHAMT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SLLV}:       ctl = entry(ALU_SLL, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SRLV}:       ctl = entry(ALU_SRL, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SRAV}:       ctl = entry(ALU_SRA, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_ADD},                                           // No overflow trap.
        {OPC_SPECIAL, 20'b?, FN_ADDU}:       ctl = entry(ALU_ADD, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SUB},
        {OPC_SPECIAL, 20'b?, FN_SUBU}:       ctl = entry(ALU_SUB, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SLT}:        ctl = entry(ALU_SLT, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_SLTU}:       ctl = entry(ALU_SLTU, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_AND}:        ctl = entry(ALU_AND, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_OR}:         ctl = entry(ALU_OR, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_XOR}:        ctl = entry(ALU_XOR, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SPECIAL, 20'b?, FN_NOR}:        ctl = entry(ALU_NOR, A0_RS, A1_RT, IMM_SEXT, 1'b1, 1'b0);
        {OPC_ADDI, 26'b?},
        {OPC_ADDIU, 26'b?}:                  ctl = entry(ALU_ADD, A0_RS, A1_IMM, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SLTI, 26'b?}:                   ctl = entry(ALU_SLT, A0_RS, A1_IMM, IMM_SEXT, 1'b1, 1'b0);
        {OPC_SLTIU, 26'b?}:                  ctl = entry(ALU_SLTU, A0_RS, A1_IMM, IMM_SEXT, 1'b1, 1'b0);
        {OPC_ANDI, 26'b?}:                   ctl = entry(ALU_AND, A0_RS, A1_IMM, IMM_ZEXT, 1'b1, 1'b0);
        {OPC_ORI, 26'b?}:                    ctl = entry(ALU_OR, A0_RS, A1_IMM, IMM_ZEXT, 1'b1, 1'b0);
        {OPC_XORI, 26'b?}:                   ctl = entry(ALU_XOR, A0_RS, A1_IMM, IMM_ZEXT, 1'b1, 1'b0);
        {OPC_LUI, 26'b?}:                    ctl = entry(ALU_OR, A0_ZERO, A1_IMM, IMM_UPPER, 1'b1, 1'b0);
        {OPC_SW, 26'b?}:                     ctl = entry(ALU_NOP, A0_ZERO, A1_ZERO, IMM_SEXT, 1'b0, 1'b1);
        default:                             ctl = entry(ALU_NOP, A0_ZERO, A1_ZERO, IMM_SEXT, 1'b0, 1'b0);
        endcase
    end

    // Unpack the table entry.
    assign tbl_wb   = ctl[12];
    assign tbl_st   = ctl[11];
    assign imm_kind = imm_kind_t'(ctl[10:9]);
    assign arg0_sel = arg0_sel_t'(ctl[8:7]);
    assign arg1_sel = arg1_sel_t'(ctl[6:5]);
    assign alu_op   = alu_op_t'(ctl[4:0]);

    // Immediate forms.
    always_comb begin
        case (imm_kind)
        IMM_ZEXT:  imm = {16'h0, ir[15:0]};
        IMM_UPPER: imm = {ir[15:0], 16'h0};     // LUI.
        IMM_SHAMT: imm = {27'h0, ir[10:6]};     // Constant shifts.
        default:   imm = {{16{ir[15]}}, ir[15:0]};
        endcase
    end

    // SPECIAL forms write rd, the others rt.
    assign rd_index = (opcode == OPC_SPECIAL) ? ir[15:11] : ir[20:16];

    assign wb_en    = ir_valid & tbl_wb & (rd_index != REG_ZERO);  // r0 never written.
    assign store_en = ir_valid & tbl_st;

endmodule

// ==== hw/mips_fetch.sv ====
// Fetch stages of the core, driving the sequential PC on the code bus and capturing the IR.
`timescale 1ns/1ns

module mips_fetch import mips_pkg::*; #(
    parameter word_t RESET_ADDR = 32'hbfc00000
) (
    input  logic  CLK,
    input  logic  RESET_I,
    input  word_t crdata,                       // Instruction for last cycle's address.
    output word_t caddr,                        // Fetch address.
    output word_t ir,                           // Instruction register.
    output logic  ir_valid                      // IR holds a real instruction.
);

    word_t pc;                                  // Address phase PC.
    logic  fd_valid;                            // Data phase carries a fetch.

    assign caddr = pc;                          // Address phase straight from PC.

    // No branches, so the PC only counts up.
    always_ff @(posedge CLK) begin
        if (RESET_I) begin
            pc <= RESET_ADDR;                   // Held at vector during reset.
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Valid bits follow the fetch from address to data phase.
    always_ff @(posedge CLK) begin
        if (RESET_I) begin
            fd_valid <= 1'b0;
            ir_valid <= 1'b0;
        end else begin
            fd_valid <= 1'b1;                   // Every cycle out of reset fetches.
            ir_valid <= fd_valid;
        end
    end

    // Data phase capture.
    always_ff @(posedge CLK) begin
        ir <= crdata;
    end

endmodule

// ==== hw/mips_alu.sv ====
// Combinational ALU of the execute stage, for arithmetic, compare, logic and shift operations.
`timescale 1ns/1ns

module mips_alu import mips_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   arg0,                       // Shift amount for shifts.
    input  word_t   arg1,                       // Shifted value for shifts.
    output word_t   result
);

    logic [32:0] arg0_ext;                      // Extended for compare.
    logic [32:0] arg1_ext;
    logic [32:0] addsub;
    word_t       arith;
    word_t       logic_res;
    word_t       shift_res;
    word_t       noarith;

    always_comb begin
        // Bit 1 set means unsigned, so zero-extend.
        arg0_ext = {(alu_op[1] ? 1'b0 : arg0[31]), arg0};
        arg1_ext = {(alu_op[1] ? 1'b0 : arg1[31]), arg1};
        addsub   = alu_op[0] ? (arg0_ext - arg1_ext) : (arg0_ext + arg1_ext);

        // SLT and SLTU keep only the sign of the difference.
        arith = alu_op[2] ? {31'h0, addsub[32]} : addsub[31:0];

        case (alu_op[1:0])
        2'b00:   logic_res = arg0 | arg1;
        2'b01:   logic_res = arg0 & arg1;
        2'b10:   logic_res = arg0 ^ arg1;
        default: logic_res = ~(arg0 | arg1);
        endcase

        case (alu_op[1:0])
        2'b00:   shift_res = arg1 << arg0[4:0];
        2'b10:   shift_res = arg1 >> arg0[4:0];
        default: shift_res = $signed(arg1) >>> arg0[4:0];    // SRA.
        endcase

        noarith = alu_op[3] ? logic_res : shift_res;
        result  = alu_op[4] ? arith : noarith;
    end

endmodule

// ==== hw/mips_pkg.sv ====
// Shared types and encodings of the MIPS integer core, imported by every RTL module and the testbench.
package mips_pkg;

    typedef logic [31:0] word_t;                // Data or address word.
    typedef logic [4:0]  reg_idx_t;             // Register index.

    localparam reg_idx_t REG_ZERO = 5'd0;       // Hardwired zero register.

    // Upper bits pick the unit, lower bits pick subtract and unsigned compare.
    typedef enum logic [4:0] {
        ALU_NOP  = 5'b00000,
        ALU_SLL  = 5'b00100,
        ALU_SRL  = 5'b00110,
        ALU_SRA  = 5'b00111,
        ALU_ADD  = 5'b10000,
        ALU_SUB  = 5'b10001,
        ALU_SLT  = 5'b10101,
        ALU_SLTU = 5'b10111,
        ALU_OR   = 5'b01000,
        ALU_AND  = 5'b01001,
        ALU_XOR  = 5'b01010,
        ALU_NOR  = 5'b01011
    } alu_op_t;

    typedef enum logic [1:0] {
        A0_ZERO  = 2'd0,                        // Constant zero.
        A0_RS    = 2'd1,                        // Register rs.
        A0_SHAMT = 2'd2                         // Shift amount from immediate.
    } arg0_sel_t;

    typedef enum logic [1:0] {
        A1_ZERO = 2'd0,                         // Constant zero.
        A1_RT   = 2'd1,                         // Register rt.
        A1_IMM  = 2'd2                          // Decoded immediate.
    } arg1_sel_t;

    typedef enum logic [1:0] {
        IMM_SEXT  = 2'd0,                       // Sign-extended low half.
        IMM_ZEXT  = 2'd1,                       // Zero-extended low half.
        IMM_UPPER = 2'd2,                       // Low half moved to upper half.
        IMM_SHAMT = 2'd3                        // The sa field.
    } imm_kind_t;

    // Primary opcodes.
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_SW      = 6'b101011;

    // SPECIAL function codes.
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage
